// File: common_bypass_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module common_bypass_buffer #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,

    input  wire      payload_t prev_data,
    input  wire      prev_valid,
    output logic     prev_ready,

    output payload_t next_data,
    output logic     next_valid,
    input  wire      next_ready
);

    payload_t buffer_q;
    logic     buffer_en;
    logic     valid_q;

    // Capture only when empty and the consumer is stalled
    assign buffer_en = !valid_q && prev_valid && !next_ready;

    always_ff @(posedge clk) begin
        if (buffer_en) begin
            buffer_q <= prev_data;
        end
    end

    // Flag holds until the consumer takes the stored entry
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!valid_q) begin
            valid_q <= prev_valid && !next_ready;
        end else begin
            valid_q <= !next_ready;
        end
    end

    // Ready comes from the flag only, so no combinational ready path
    assign prev_ready = !valid_q;

    assign next_data  = valid_q ? buffer_q : prev_data;
    assign next_valid = valid_q || prev_valid;

    // Offered entry must hold until the consumer takes it
    assert property (@(posedge clk) disable iff (reset)
        next_valid && !next_ready |=> next_valid && $stable(next_data));

    // While full, upstream keeps its pending item until the flag clears
    assert property (@(posedge clk) disable iff (reset)
        valid_q && prev_valid |=> prev_valid && $stable(prev_data));

endmodule

`default_nettype wire

// File: decode_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_pipe_top
    import taurus_decode_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire             in_valid,
    output logic            in_ready,
    input  wire [xlen-1:0]  in_pc,
    input  wire [31:0]      in_inst,

    output logic            out_valid,
    input  wire             out_ready,
    output logic [xlen-1:0] out_pc,
    output inst_fmt_e       out_fmt,
    output logic [4:0]      out_rd,
    output logic [xlen-1:0] out_imm,
    output logic [xlen-1:0] out_target
);

    // Decode to buffer_a to immediate stage
    decoded_t dec_data, imm_in_data;
    logic     dec_valid, dec_ready;
    logic     imm_in_valid, imm_in_ready;

    // Immediate stage to buffer_b to target stage
    immed_t   imm_data, tgt_in_data;
    logic     imm_valid, imm_ready;
    logic     tgt_in_valid, tgt_in_ready;

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .out_valid (dec_valid),
        .out_data  (dec_data),
        .out_ready (dec_ready)
    );

    common_bypass_buffer #(
        .payload_t (decoded_t)
    ) buffer_a (
        .clk        (clk),
        .reset      (reset),
        .prev_data  (dec_data),
        .prev_valid (dec_valid),
        .prev_ready (dec_ready),
        .next_data  (imm_in_data),
        .next_valid (imm_in_valid),
        .next_ready (imm_in_ready)
    );

    imm_gen_stage u_imm_gen (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (imm_in_valid),
        .in_ready  (imm_in_ready),
        .in_data   (imm_in_data),
        .out_valid (imm_valid),
        .out_data  (imm_data),
        .out_ready (imm_ready)
    );

    common_bypass_buffer #(
        .payload_t (immed_t)
    ) buffer_b (
        .clk        (clk),
        .reset      (reset),
        .prev_data  (imm_data),
        .prev_valid (imm_valid),
        .prev_ready (imm_ready),
        .next_data  (tgt_in_data),
        .next_valid (tgt_in_valid),
        .next_ready (tgt_in_ready)
    );

    target_calc_stage u_target_calc (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (tgt_in_valid),
        .in_ready   (tgt_in_ready),
        .in_data    (tgt_in_data),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_fmt    (out_fmt),
        .out_rd     (out_rd),
        .out_imm    (out_imm),
        .out_target (out_target),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import taurus_decode_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire             in_valid,
    output logic            in_ready,
    input  wire [xlen-1:0]  in_pc,
    input  wire [31:0]      in_inst,

    output logic            out_valid,
    output decoded_t        out_data,
    input  wire             out_ready
);

    inst_fmt_e  fmt_d;
    logic [4:0] rd_d;
    logic [6:0] opcode;

    assign opcode = in_inst[6:0];

    // Opcode to format
    always_comb begin
        case (opcode)
            op_op, op_op_32:                 fmt_d = fmt_r;
            op_op_imm, op_op_imm_32, op_load,
            op_jalr, op_system:              fmt_d = fmt_i;
            op_store:                        fmt_d = fmt_s;
            op_branch:                       fmt_d = fmt_b;
            op_lui, op_auipc:                fmt_d = fmt_u;
            op_jal:                          fmt_d = fmt_j;
            default:                         fmt_d = fmt_illegal;
        endcase
        // Compressed encodings are not supported here
        if (in_inst[1:0] != 2'b11) begin
            fmt_d = fmt_illegal;
        end
    end

    // S and B reuse the rd field for immediate bits
    assign rd_d = (fmt_d == fmt_s || fmt_d == fmt_b) ? 5'd0 : in_inst[11:7];

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data.pc   <= in_pc;
            out_data.inst <= in_inst;
            out_data.fmt  <= fmt_d;
            out_data.rd   <= rd_d;
        end
    end

    // Offered record, format included, carries no unknown bits
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(out_data));

endmodule

`default_nettype wire

// File: files.f
+incdir+.
taurus_decode_pkg.sv
common_bypass_buffer.sv
decode_stage.sv
imm_gen_stage.sv
target_calc_stage.sv
decode_pipe_top.sv
tb_decode_pipe.sv

// File: imm_gen_stage.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen_stage
    import taurus_decode_pkg::*;
(
    input  wire            clk,
    input  wire            reset,

    input  wire            in_valid,
    output logic           in_ready,
    input  wire decoded_t  in_data,

    output logic           out_valid,
    output immed_t         out_data,
    input  wire            out_ready
);

    logic [31:0]     inst;
    logic [xlen-1:0] imm_d;

    assign inst = in_data.inst;

    // Standard RISC-V immediate layouts, all sign-extended from inst[31]
    always_comb begin
        case (in_data.fmt)
            fmt_i:   imm_d = {{(xlen-12){inst[31]}}, inst[31:20]};
            fmt_s:   imm_d = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   imm_d = {{(xlen-13){inst[31]}}, inst[31], inst[7],
                              inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm_d = {{(xlen-32){inst[31]}}, inst[31:12], 12'd0};
            fmt_j:   imm_d = {{(xlen-21){inst[31]}}, inst[31], inst[19:12],
                              inst[20], inst[30:21], 1'b0};
            // R and illegal carry no immediate
            default: imm_d = '0;
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data.pc     <= in_data.pc;
            out_data.opcode <= inst[6:0];
            out_data.fmt    <= in_data.fmt;
            out_data.rd     <= in_data.rd;
            out_data.imm    <= imm_d;
        end
    end

    // Held item stays put until the buffer downstream takes it
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the decode pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -j 0 -f files.f \
    --top-module tb_decode_pipe -o tb_decode_pipe > "$build_log" 2>&1
status=$?
cat "$build_log"
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/tb_decode_pipe > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$sim_log"; then
    exit 1
fi
exit 0

// File: target_calc_stage.sv
`timescale 1ns/1ps
`default_nettype none

module target_calc_stage
    import taurus_decode_pkg::*;
(
    input  wire             clk,
    input  wire             reset,

    input  wire             in_valid,
    output logic            in_ready,
    input  wire immed_t     in_data,

    output logic            out_valid,
    output logic [xlen-1:0] out_pc,
    output inst_fmt_e       out_fmt,
    output logic [4:0]      out_rd,
    output logic [xlen-1:0] out_imm,
    output logic [xlen-1:0] out_target,
    input  wire             out_ready
);

    logic [xlen-1:0] target_d;

    // jalr falls into the link address case, rs1 is not available here
    always_comb begin
        case (in_data.opcode)
            op_branch, op_jal, op_auipc: target_d = in_data.pc + in_data.imm;
            op_lui:                      target_d = in_data.imm;
            default:                     target_d = in_data.pc + xlen'(4);
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_pc     <= in_data.pc;
            out_fmt    <= in_data.fmt;
            out_rd     <= in_data.rd;
            out_imm    <= in_data.imm;
            out_target <= target_d;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_fmt)
            && $stable(out_rd) && $stable(out_imm) && $stable(out_target));

endmodule

`default_nettype wire

// File: taurus_decode_pkg.sv
`default_nettype none

package taurus_decode_pkg;

    // Data and address width
    localparam int xlen = 64;

    // Instruction formats seen by the front end
    typedef enum logic [2:0] {
        fmt_r       = 3'd0,
        fmt_i       = 3'd1,
        fmt_s       = 3'd2,
        fmt_b       = 3'd3,
        fmt_u       = 3'd4,
        fmt_j       = 3'd5,
        fmt_illegal = 3'd6
    } inst_fmt_e;

    // RV64I major opcodes, inst[6:0]
    localparam logic [6:0] op_lui       = 7'b0110111;
    localparam logic [6:0] op_auipc     = 7'b0010111;
    localparam logic [6:0] op_jal       = 7'b1101111;
    localparam logic [6:0] op_jalr      = 7'b1100111;
    localparam logic [6:0] op_branch    = 7'b1100011;
    localparam logic [6:0] op_load      = 7'b0000011;
    localparam logic [6:0] op_store     = 7'b0100011;
    localparam logic [6:0] op_op_imm    = 7'b0010011;
    localparam logic [6:0] op_op        = 7'b0110011;
    localparam logic [6:0] op_op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_op_32     = 7'b0111011;
    localparam logic [6:0] op_system    = 7'b1110011;

    // Decode to immediate stage, 104 bits
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        inst_fmt_e       fmt;
        logic [4:0]      rd;
    } decoded_t;

    // Immediate to target stage, 143 bits
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [6:0]      opcode;
        inst_fmt_e       fmt;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;
    } immed_t;

endpackage

`default_nettype wire

// File: decode_ref.svh
`ifndef decode_ref_svh
`define decode_ref_svh

// Expected values for one instruction at the pipeline output
typedef struct packed {
    logic [xlen-1:0] pc;
    inst_fmt_e       fmt;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] target;
} exp_rec_t;

// Sign-extend a field held in the low width bits
function automatic logic [xlen-1:0] sign_extend(input logic [31:0] field, input int width);
    logic signed [xlen-1:0] wide;
    wide = {field, 32'd0};
    wide = wide <<< (32 - width);
    return wide >>> (xlen - width);
endfunction

function automatic exp_rec_t ref_decode(input logic [xlen-1:0] pc, input logic [31:0] inst);
    exp_rec_t   rec;
    logic [6:0] opcode;
    opcode = inst[6:0];
    rec.pc = pc;
    case (opcode)
        op_op, op_op_32:                                      rec.fmt = fmt_r;
        op_op_imm, op_op_imm_32, op_load, op_jalr, op_system: rec.fmt = fmt_i;
        op_store:                                             rec.fmt = fmt_s;
        op_branch:                                            rec.fmt = fmt_b;
        op_lui, op_auipc:                                     rec.fmt = fmt_u;
        op_jal:                                               rec.fmt = fmt_j;
        default:                                              rec.fmt = fmt_illegal;
    endcase
    // Only full 32-bit encodings end in 11
    if (inst[1:0] != 2'b11) begin
        rec.fmt = fmt_illegal;
    end
    rec.rd = (rec.fmt == fmt_s || rec.fmt == fmt_b) ? 5'd0 : inst[11:7];
    case (rec.fmt)
        fmt_i:   rec.imm = sign_extend({20'd0, inst[31:20]}, 12);
        fmt_s:   rec.imm = sign_extend({20'd0, inst[31:25], inst[11:7]}, 12);
        fmt_b:   rec.imm = sign_extend({19'd0, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0}, 13);
        fmt_u:   rec.imm = sign_extend({inst[31:12], 12'd0}, 32);
        fmt_j:   rec.imm = sign_extend({11'd0, inst[31], inst[19:12], inst[20],
                                        inst[30:21], 1'b0}, 21);
        default: rec.imm = '0;
    endcase
    // Illegal encodings never match these opcodes
    case (opcode)
        op_branch, op_jal, op_auipc: rec.target = pc + rec.imm;
        op_lui:                      rec.target = rec.imm;
        default:                     rec.target = pc + 64'd4;
    endcase
    return rec;
endfunction

`endif

// File: tb_decode_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_pipe
    import taurus_decode_pkg::*;
();

    `include "decode_ref.svh"

    localparam int n_directed = 12;
    localparam int n_illegal  = 5;
    localparam int n_stream   = 16;
    localparam int n_random   = 300;
    localparam int timeout_cycles =
        (n_directed + n_illegal + n_stream + n_random) * 20 + 200;

    // One of each opcode class, several with negative immediates
    localparam logic [31:0] directed_insts [n_directed] = '{
        32'hfffff2b7,  // lui    x5, 0xfffff
        32'h12345317,  // auipc  x6, 0x12345
        32'hff9ff0ef,  // jal    x1, -8
        32'hffc100e7,  // jalr   x1, -4(x2)
        32'hfe2088e3,  // beq    x1, x2, -16
        32'hff81b383,  // ld     x7, -8(x3)
        32'hfe513423,  // sd     x5, -24(x2)
        32'h07b00513,  // addi   x10, x0, 123
        32'h002081b3,  // add    x3, x1, x2
        32'h402081bb,  // subw   x3, x1, x2
        32'h00000073,  // ecall
        32'hfff5051b   // addiw  x10, x10, -1
    };

    // Unknown opcodes and low bits other than 11
    localparam logic [31:0] illegal_insts [n_illegal] = '{
        32'h0000007f, 32'h12345678, 32'hfffffffe, 32'h0000000b, 32'h00000000
    };

    localparam logic [6:0] opcode_list [12] = '{
        op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load,
        op_store, op_op_imm, op_op, op_op_imm_32, op_op_32, op_system
    };

    logic            clk;
    logic            reset;
    logic            in_valid;
    logic            in_ready;
    logic [xlen-1:0] in_pc;
    logic [31:0]     in_inst;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_pc;
    inst_fmt_e       out_fmt;
    logic [4:0]      out_rd;
    logic [xlen-1:0] out_imm;
    logic [xlen-1:0] out_target;

    exp_rec_t exp_q[$];
    int       accept_q[$];
    int       cycle = 0;
    int       prev_out_cycle = -1;
    int       in_count = 0;
    int       out_count = 0;
    int       error_count = 0;
    int       test_errors = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;
    bit       stream_mode = 1'b0;
    bit       random_stall = 1'b0;
    integer   seed;

    decode_pipe_top UUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pc      (in_pc),
        .in_inst    (in_inst),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pc     (out_pc),
        .out_fmt    (out_fmt),
        .out_rd     (out_rd),
        .out_imm    (out_imm),
        .out_target (out_target)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_mismatch(input string field, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] want);
        $display("FAIL %0t: %s is %h, expected %h", $time, field, got, want);
        error_count++;
    endtask

    // Step to just after the next rising edge, out_ready changes only here
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #2;
        rnd = $random(seed);
        out_ready = random_stall ? rnd[0] : 1'b1;
    endtask

    // Hold the instruction until the decode stage takes it
    task automatic send_inst(input logic [xlen-1:0] pc, input logic [31:0] inst);
        logic taken;
        in_valid = 1'b1;
        in_pc    = pc;
        in_inst  = inst;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            if (taken) begin
                exp_q.push_back(ref_decode(pc, inst));
                accept_q.push_back(cycle);
                in_count++;
            end
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    function automatic logic [31:0] random_inst();
        logic [31:0] body;
        logic [31:0] sel;
        body = $random(seed);
        sel  = $random(seed);
        if (sel[3:0] < 4'd12) begin
            return {body[31:7], opcode_list[sel[3:0]]};
        end
        // Mostly unknown opcodes
        return body;
    endfunction

    task automatic check_output();
        exp_rec_t exp;
        int       accepted;
        out_count++;
        if (exp_q.size() == 0) begin
            $display("Error at %0t: an output with pc %h arrived with no instruction pending",
                     $time, out_pc);
            error_count++;
        end else begin
            exp = exp_q.pop_front();
            accepted = accept_q.pop_front();
            assert (out_pc == exp.pc) else report_mismatch("pc", out_pc, exp.pc);
            assert (out_fmt == exp.fmt)
                else report_mismatch("fmt", xlen'(out_fmt), xlen'(exp.fmt));
            assert (out_rd == exp.rd) else report_mismatch("rd", xlen'(out_rd), xlen'(exp.rd));
            assert (out_imm == exp.imm) else report_mismatch("imm", out_imm, exp.imm);
            assert (out_target == exp.target)
                else report_mismatch("target", out_target, exp.target);
            if (stream_mode) begin
                assert (cycle - accepted == 3)
                    else report_mismatch("latency", xlen'(cycle - accepted), xlen'(3));
                if (prev_out_cycle >= 0) begin
                    assert (cycle - prev_out_cycle == 1)
                        else report_mismatch("output spacing", xlen'(cycle - prev_out_cycle),
                                             xlen'(1));
                end
                prev_out_cycle = cycle;
            end
        end
    endtask

    // Handshake values are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            check_output();
        end
    end

    task automatic check_reset_state();
        assert (!out_valid) else report_mismatch("out_valid", xlen'(out_valid), '0);
        assert (in_ready) else report_mismatch("in_ready", xlen'(in_ready), xlen'(1));
    endtask

    // Extra cycles after the queue empties expose duplicates
    task automatic wait_drain();
        random_stall = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        logic [31:0] gap;
        logic [31:0] hi;
        logic [31:0] lo;
        seed      = 27;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        out_ready = 1'b1;

        // Seven reset edges checked here, the eighth releases reset
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_state();
        end
        @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        next_cycle();
        finish_test("reset state");

        for (int i = 0; i < n_directed; i++) begin
            send_inst(64'h0000_0000_8000_0000 + xlen'(i * 4), directed_insts[i]);
        end
        wait_drain();
        finish_test("directed formats");

        // pc near the top of the address space so pc + 4 wraps
        for (int i = 0; i < n_illegal; i++) begin
            send_inst(64'hffff_ffff_ffff_fff8 + xlen'(i * 4), illegal_insts[i]);
        end
        wait_drain();
        finish_test("illegal opcodes");

        stream_mode    = 1'b1;
        prev_out_cycle = -1;
        for (int i = 0; i < n_stream; i++) begin
            send_inst(64'h0000_0000_0001_0000 + xlen'(i * 4), random_inst());
        end
        wait_drain();
        stream_mode = 1'b0;
        finish_test("streaming latency");

        random_stall = 1'b1;
        for (int i = 0; i < n_random; i++) begin
            gap = $random(seed);
            if (gap[0]) begin
                next_cycle();
            end
            hi = $random(seed);
            lo = $random(seed);
            send_inst({hi, lo[31:2], 2'b00}, random_inst());
        end
        wait_drain();
        if (exp_q.size() != 0 || out_count != in_count) begin
            $display("Error: %0d instructions were accepted but %0d outputs came out",
                     in_count, out_count);
            error_count++;
        end
        finish_test("random back-pressure");

        $display("Summary: %0d tests ok, %0d tests with errors, %0d outputs, %0d errors",
                 tests_passed, tests_failed, out_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the pipeline stalled and not all instructions came out");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
